// ==== design/riscv_pkg.sv ====
package riscv_pkg;

    localparam int XLEN     = 32;
    localparam int NUM_REGS = 32;
    localparam int REG_AW   = $clog2(NUM_REGS);

    typedef logic [XLEN-1:0]   word_t;
    typedef logic [31:0]       inst_t;     // RV32 base, always 32 bit
    typedef logic [REG_AW-1:0] reg_addr_t;
    typedef logic [6:0]        opcode_t;
    typedef logic [2:0]        funct3_t;
    typedef logic [6:0]        funct7_t;

    // major opcodes, only the kept groups
    localparam opcode_t OPC_LUI    = 7'b0110111;
    localparam opcode_t OPC_AUIPC  = 7'b0010111;
    localparam opcode_t OPC_OP_IMM = 7'b0010011;
    localparam opcode_t OPC_OP     = 7'b0110011;
    localparam opcode_t OPC_LOAD   = 7'b0000011;

    // funct3, same for OP and OP-IMM
    localparam funct3_t F3_ADD  = 3'b000;
    localparam funct3_t F3_SLL  = 3'b001;
    localparam funct3_t F3_SLT  = 3'b010;
    localparam funct3_t F3_SLTU = 3'b011;
    localparam funct3_t F3_XOR  = 3'b100;
    localparam funct3_t F3_SR   = 3'b101;  // srl / sra
    localparam funct3_t F3_OR   = 3'b110;
    localparam funct3_t F3_AND  = 3'b111;

    localparam funct3_t F3_LB  = 3'b000;
    localparam funct3_t F3_LH  = 3'b001;
    localparam funct3_t F3_LW  = 3'b010;
    localparam funct3_t F3_LBU = 3'b100;
    localparam funct3_t F3_LHU = 3'b101;

    localparam funct7_t F7_BASE = 7'b0000000;
    localparam funct7_t F7_ALT  = 7'b0100000;  // sub, sra

    // NONE must stay at zero, a cleared record is a bubble
    typedef enum logic [4:0] {
        ALU_NONE,
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_LUI,
        ALU_LB,
        ALU_LH,
        ALU_LW,
        ALU_LBU,
        ALU_LHU
    } alu_op_e;

    typedef enum logic [2:0] {
        RES_NONE,
        RES_LOGIC,
        RES_SHIFT,
        RES_ARITH,
        RES_COMPARE,
        RES_LOAD
    } alu_sel_e;

endpackage

// ==== design/pipe_pkg.sv ====
package pipe_pkg;

    // decoder output, consumed within the decode stage
    typedef struct packed {
        riscv_pkg::alu_op_e   aluop;
        riscv_pkg::alu_sel_e  alusel;
        riscv_pkg::reg_addr_t rs1;
        riscv_pkg::reg_addr_t rs2;
        logic                 rs1_read;
        logic                 rs2_read;
        riscv_pkg::reg_addr_t rd;
        logic                 wreg;
        riscv_pkg::word_t     imm1;    // pc for auipc, else zero
        riscv_pkg::word_t     imm2;
        logic                 illegal;
    } decode_t;

    // result offered back by execute or memory
    typedef struct packed {
        logic                 wreg;
        riscv_pkg::reg_addr_t rd;
        riscv_pkg::word_t     wdata;
        logic                 is_load; // only driven by execute
    } fwd_t;

    typedef struct packed {
        logic                 we;
        riscv_pkg::reg_addr_t addr;
        riscv_pkg::word_t     data;
    } wb_t;

    // decode to execute record
    typedef struct packed {
        logic                 valid;
        riscv_pkg::word_t     pc;
        riscv_pkg::alu_op_e   aluop;
        riscv_pkg::alu_sel_e  alusel;
        riscv_pkg::word_t     op1;
        riscv_pkg::word_t     op2;
        riscv_pkg::reg_addr_t rd;
        logic                 wreg;
        logic                 illegal;
    } issue_t;

endpackage

// ==== design/inst_decoder.sv ====
`timescale 1ns/1ps

module inst_decoder (
    input  riscv_pkg::word_t  pc_i,
    input  riscv_pkg::inst_t  inst_i,
    output pipe_pkg::decode_t dec_o
);

    riscv_pkg::opcode_t opcode;
    riscv_pkg::funct3_t funct3;
    riscv_pkg::funct7_t funct7;
    riscv_pkg::word_t   imm_i;
    riscv_pkg::word_t   imm_sh;
    riscv_pkg::word_t   imm_u;
    logic               f7_base;
    logic               f7_alt;

    assign opcode  = inst_i[6:0];
    assign funct3  = inst_i[14:12];
    assign funct7  = inst_i[31:25];
    assign f7_base = (funct7 == riscv_pkg::F7_BASE);
    assign f7_alt  = (funct7 == riscv_pkg::F7_ALT);

    assign imm_i  = {{20{inst_i[31]}}, inst_i[31:20]};  // sign extended
    assign imm_sh = riscv_pkg::word_t'(inst_i[24:20]);  // shamt
    assign imm_u  = {inst_i[31:12], 12'b0};

    always_comb begin
        dec_o         = '0;
        dec_o.rs1     = inst_i[19:15];
        dec_o.rs2     = inst_i[24:20];
        dec_o.rd      = inst_i[11:7];
        dec_o.illegal = 1'b1;   // kept groups clear it

        case (opcode)
            riscv_pkg::OPC_LUI: begin
                dec_o.aluop   = riscv_pkg::ALU_LUI;
                dec_o.alusel  = riscv_pkg::RES_SHIFT;
                dec_o.imm2    = imm_u;
                dec_o.wreg    = 1'b1;
                dec_o.illegal = 1'b0;
            end
            riscv_pkg::OPC_AUIPC: begin
                dec_o.aluop   = riscv_pkg::ALU_ADD;
                dec_o.alusel  = riscv_pkg::RES_ARITH;
                dec_o.imm1    = pc_i;
                dec_o.imm2    = imm_u;
                dec_o.wreg    = 1'b1;
                dec_o.illegal = 1'b0;
            end
            riscv_pkg::OPC_LOAD: begin
                dec_o.alusel   = riscv_pkg::RES_LOAD;
                dec_o.rs1_read = 1'b1;
                dec_o.imm2     = imm_i;     // address offset
                dec_o.wreg     = 1'b1;
                dec_o.illegal  = 1'b0;
                case (funct3)
                    riscv_pkg::F3_LB:  dec_o.aluop = riscv_pkg::ALU_LB;
                    riscv_pkg::F3_LH:  dec_o.aluop = riscv_pkg::ALU_LH;
                    riscv_pkg::F3_LW:  dec_o.aluop = riscv_pkg::ALU_LW;
                    riscv_pkg::F3_LBU: dec_o.aluop = riscv_pkg::ALU_LBU;
                    riscv_pkg::F3_LHU: dec_o.aluop = riscv_pkg::ALU_LHU;
                    default:           dec_o.illegal = 1'b1;
                endcase
            end
            riscv_pkg::OPC_OP_IMM, riscv_pkg::OPC_OP: begin
                dec_o.rs1_read = 1'b1;
                dec_o.rs2_read = (opcode == riscv_pkg::OPC_OP);
                dec_o.imm2     = dec_o.rs2_read ? '0 : imm_i;
                dec_o.wreg     = 1'b1;
                // funct7 only matters for reg-reg ops and immediate shifts
                dec_o.illegal  = dec_o.rs2_read && !f7_base;
                case (funct3)
                    riscv_pkg::F3_ADD: begin
                        dec_o.alusel = riscv_pkg::RES_ARITH;
                        if (dec_o.rs2_read && inst_i[30]) begin
                            dec_o.aluop   = riscv_pkg::ALU_SUB;
                            dec_o.illegal = !f7_alt;
                        end else begin
                            dec_o.aluop = riscv_pkg::ALU_ADD;
                        end
                    end
                    riscv_pkg::F3_SLL: begin
                        dec_o.aluop   = riscv_pkg::ALU_SLL;
                        dec_o.alusel  = riscv_pkg::RES_SHIFT;
                        dec_o.illegal = !f7_base;
                        if (!dec_o.rs2_read) dec_o.imm2 = imm_sh;
                    end
                    riscv_pkg::F3_SR: begin
                        dec_o.aluop   = inst_i[30] ? riscv_pkg::ALU_SRA : riscv_pkg::ALU_SRL;
                        dec_o.alusel  = riscv_pkg::RES_SHIFT;
                        dec_o.illegal = !(f7_base || f7_alt);
                        if (!dec_o.rs2_read) dec_o.imm2 = imm_sh;
                    end
                    riscv_pkg::F3_SLT: begin
                        dec_o.aluop  = riscv_pkg::ALU_SLT;
                        dec_o.alusel = riscv_pkg::RES_COMPARE;
                    end
                    riscv_pkg::F3_SLTU: begin
                        dec_o.aluop  = riscv_pkg::ALU_SLTU;
                        dec_o.alusel = riscv_pkg::RES_COMPARE;
                    end
                    riscv_pkg::F3_XOR: begin
                        dec_o.aluop  = riscv_pkg::ALU_XOR;
                        dec_o.alusel = riscv_pkg::RES_LOGIC;
                    end
                    riscv_pkg::F3_OR: begin
                        dec_o.aluop  = riscv_pkg::ALU_OR;
                        dec_o.alusel = riscv_pkg::RES_LOGIC;
                    end
                    default: begin
                        dec_o.aluop  = riscv_pkg::ALU_AND;
                        dec_o.alusel = riscv_pkg::RES_LOGIC;
                    end
                endcase
            end
            default: ;
        endcase

        // illegal issues as a bubble, no reads so no stall
        if (dec_o.illegal) begin
            dec_o.aluop    = riscv_pkg::ALU_NONE;
            dec_o.alusel   = riscv_pkg::RES_NONE;
            dec_o.rs1_read = 1'b0;
            dec_o.rs2_read = 1'b0;
            dec_o.wreg     = 1'b0;
        end
    end

endmodule

// ==== design/regfile.sv ====
`timescale 1ns/1ps

module regfile (
    input  logic                 clk,
    input  logic                 rst_n_i,
    input  pipe_pkg::wb_t        wb_i,
    input  riscv_pkg::reg_addr_t raddr1_i,
    input  riscv_pkg::reg_addr_t raddr2_i,
    output riscv_pkg::word_t     rdata1_o,
    output riscv_pkg::word_t     rdata2_o
);

    riscv_pkg::word_t regs [riscv_pkg::NUM_REGS];

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < riscv_pkg::NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_i.we && wb_i.addr != '0) begin  // x0 stays zero
            regs[wb_i.addr] <= wb_i.data;
        end
    end

    // no write-through, memory stage forwarding covers it
    assign rdata1_o = regs[raddr1_i];
    assign rdata2_o = regs[raddr2_i];

endmodule

// ==== design/operand_select.sv ====
`timescale 1ns/1ps

module operand_select (
    input  pipe_pkg::decode_t dec_i,
    input  riscv_pkg::word_t  rdata1_i,
    input  riscv_pkg::word_t  rdata2_i,
    input  pipe_pkg::fwd_t    ex_fwd_i,
    input  pipe_pkg::fwd_t    mem_fwd_i,
    output riscv_pkg::word_t  op1_o,
    output riscv_pkg::word_t  op2_o,
    output logic              stall_o
);

    logic stall1;
    logic stall2;

    // one operand, priority order matters
    function automatic riscv_pkg::word_t pick_operand(
        input  logic                 rd_en,
        input  riscv_pkg::reg_addr_t addr,
        input  riscv_pkg::word_t     imm,
        input  riscv_pkg::word_t     rdata,
        input  pipe_pkg::fwd_t       ex,
        input  pipe_pkg::fwd_t       mem,
        output logic                 stall
    );
        stall = 1'b0;
        if (!rd_en) return imm;
        if (addr == '0) return '0;
        if (ex.is_load && ex.rd == addr) begin
            stall = 1'b1;   // load data not there until memory
            return '0;
        end
        if (ex.wreg && ex.rd == addr) return ex.wdata;
        if (mem.wreg && mem.rd == addr) return mem.wdata;
        return rdata;
    endfunction

    always_comb begin
        op1_o = pick_operand(dec_i.rs1_read, dec_i.rs1, dec_i.imm1, rdata1_i,
                             ex_fwd_i, mem_fwd_i, stall1);
        op2_o = pick_operand(dec_i.rs2_read, dec_i.rs2, dec_i.imm2, rdata2_i,
                             ex_fwd_i, mem_fwd_i, stall2);
    end

    assign stall_o = stall1 | stall2;

endmodule

// ==== design/id_ex_reg.sv ====
`timescale 1ns/1ps

module id_ex_reg (
    input  logic              clk,
    input  logic              rst_n_i,
    input  logic              inst_valid_i,
    input  logic              stall_i,
    input  riscv_pkg::word_t  pc_i,
    input  pipe_pkg::decode_t dec_i,
    input  riscv_pkg::word_t  op1_i,
    input  riscv_pkg::word_t  op2_i,
    output pipe_pkg::issue_t  issue_o
);

    pipe_pkg::issue_t issue_d;

    always_comb begin
        issue_d.valid   = 1'b1;
        issue_d.pc      = pc_i;
        issue_d.aluop   = dec_i.aluop;
        issue_d.alusel  = dec_i.alusel;
        issue_d.op1     = op1_i;
        issue_d.op2     = op2_i;
        issue_d.rd      = dec_i.rd;
        issue_d.wreg    = dec_i.wreg;
        issue_d.illegal = dec_i.illegal;
        if (stall_i || !inst_valid_i) begin   // bubble
            issue_d.valid   = 1'b0;
            issue_d.aluop   = riscv_pkg::ALU_NONE;
            issue_d.alusel  = riscv_pkg::RES_NONE;
            issue_d.wreg    = 1'b0;
            issue_d.illegal = 1'b0;
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            issue_o <= '0;
        end else begin
            issue_o <= issue_d;
        end
    end

endmodule

// ==== design/decode_stage.sv ====
`timescale 1ns/1ps

module decode_stage (
    input  logic             clk,
    input  logic             rst_n_i,
    input  logic             inst_valid_i,
    input  riscv_pkg::word_t pc_i,
    input  riscv_pkg::inst_t inst_i,
    output logic             ready_o,
    input  pipe_pkg::fwd_t   ex_fwd_i,
    input  pipe_pkg::fwd_t   mem_fwd_i,
    input  pipe_pkg::wb_t    wb_i,
    output pipe_pkg::issue_t issue_o
);

    pipe_pkg::decode_t dec;
    riscv_pkg::word_t  rdata1;
    riscv_pkg::word_t  rdata2;
    riscv_pkg::word_t  op1;
    riscv_pkg::word_t  op2;
    logic              stall;

    assign ready_o = ~stall;   // fetch holds inst while low

    inst_decoder u_dec (
        .pc_i   (pc_i),
        .inst_i (inst_i),
        .dec_o  (dec)
    );

    regfile u_rf (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .wb_i     (wb_i),
        .raddr1_i (dec.rs1),
        .raddr2_i (dec.rs2),
        .rdata1_o (rdata1),
        .rdata2_o (rdata2)
    );

    operand_select u_opsel (
        .dec_i     (dec),
        .rdata1_i  (rdata1),
        .rdata2_i  (rdata2),
        .ex_fwd_i  (ex_fwd_i),
        .mem_fwd_i (mem_fwd_i),
        .op1_o     (op1),
        .op2_o     (op2),
        .stall_o   (stall)
    );

    id_ex_reg u_id_ex (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .inst_valid_i (inst_valid_i),
        .stall_i      (stall),
        .pc_i         (pc_i),
        .dec_i        (dec),
        .op1_i        (op1),
        .op2_i        (op2),
        .issue_o      (issue_o)
    );

endmodule

// ==== dv/decode_stage_assert.sv ====
`timescale 1ns/1ps

module decode_stage_assert (
    input logic             clk,
    input logic             rst_n_i,
    input logic             ready_i,
    input pipe_pkg::issue_t issue_i
);

    int fails = 0;

    a_reset_clear: assert property (@(posedge clk) !rst_n_i |-> !issue_i.valid)
        else begin
            $error("issue_o.valid high during reset");
            fails++;
        end

    // stall turns into a bubble one edge later
    a_stall_bubble: assert property (@(posedge clk) disable iff (!rst_n_i)
        !ready_i |=> !issue_i.valid && !issue_i.wreg && issue_i.aluop == riscv_pkg::ALU_NONE)
        else begin
            $error("no bubble after a stall cycle");
            fails++;
        end

    a_illegal_no_write: assert property (@(posedge clk) disable iff (!rst_n_i)
        issue_i.illegal |-> !issue_i.wreg)
        else begin
            $error("illegal issue with wreg set");
            fails++;
        end

endmodule

bind decode_stage decode_stage_assert u_assert (
    .clk     (clk),
    .rst_n_i (rst_n_i),
    .ready_i (ready_o),
    .issue_i (issue_o)
);

// ==== dv/decode_checker.sv ====
`timescale 1ns/1ps

module decode_checker (
    input logic             clk,
    input logic             rst_n_i,
    input logic             inst_valid_i,
    input riscv_pkg::word_t pc_i,
    input riscv_pkg::inst_t inst_i,
    input logic             ready_i,
    input pipe_pkg::fwd_t   ex_fwd_i,
    input pipe_pkg::fwd_t   mem_fwd_i,
    input pipe_pkg::wb_t    wb_i,
    input pipe_pkg::issue_t issue_i
);

    riscv_pkg::word_t shadow [riscv_pkg::NUM_REGS];  // register file as seen from writeback
    pipe_pkg::issue_t exp_q;
    logic             exp_valid = 1'b0;
    logic             exp_stall;
    string            test_name = "idle";
    int               tests = 0;
    int               checks = 0;
    int               errors = 0;
    int               test_errors = 0;

    function automatic riscv_pkg::word_t expected_operand(
        input  logic                 used,
        input  riscv_pkg::reg_addr_t addr,
        input  riscv_pkg::word_t     imm,
        output logic                 stall
    );
        stall = 1'b0;
        if (!used) return imm;
        if (addr == '0) return '0;
        if (ex_fwd_i.is_load && ex_fwd_i.rd == addr) begin
            stall = 1'b1;
            return '0;
        end
        if (ex_fwd_i.wreg && ex_fwd_i.rd == addr) return ex_fwd_i.wdata;
        if (mem_fwd_i.wreg && mem_fwd_i.rd == addr) return mem_fwd_i.wdata;
        return shadow[addr];
    endfunction

    // expected record for one accepted instruction
    function automatic pipe_pkg::issue_t ref_issue(
        input  riscv_pkg::inst_t inst,
        input  riscv_pkg::word_t pc,
        output logic             stall
    );
        pipe_pkg::issue_t   r;
        riscv_pkg::funct7_t f7;
        riscv_pkg::word_t   imm2;
        logic               reg_op;
        logic               use1;
        logic               ok;
        logic               s1;
        logic               s2;
        r = '0;
        r.valid = 1'b1;
        r.pc = pc;
        r.rd = inst[11:7];
        f7 = inst[31:25];
        reg_op = (inst[6:0] == riscv_pkg::OPC_OP);
        use1 = 1'b1;
        ok = 1'b1;
        stall = 1'b0;
        imm2 = {{20{inst[31]}}, inst[31:20]};
        case (inst[6:0])
            riscv_pkg::OPC_LUI: begin
                r.aluop = riscv_pkg::ALU_LUI;
                r.alusel = riscv_pkg::RES_SHIFT;
                use1 = 1'b0;
                imm2 = {inst[31:12], 12'h000};
            end
            riscv_pkg::OPC_AUIPC: begin
                r.aluop = riscv_pkg::ALU_ADD;
                r.alusel = riscv_pkg::RES_ARITH;
                use1 = 1'b0;
                r.op1 = pc;
                imm2 = {inst[31:12], 12'h000};
            end
            riscv_pkg::OPC_LOAD: begin
                r.alusel = riscv_pkg::RES_LOAD;
                case (inst[14:12])
                    riscv_pkg::F3_LB:  r.aluop = riscv_pkg::ALU_LB;
                    riscv_pkg::F3_LH:  r.aluop = riscv_pkg::ALU_LH;
                    riscv_pkg::F3_LW:  r.aluop = riscv_pkg::ALU_LW;
                    riscv_pkg::F3_LBU: r.aluop = riscv_pkg::ALU_LBU;
                    riscv_pkg::F3_LHU: r.aluop = riscv_pkg::ALU_LHU;
                    default:           ok = 1'b0;
                endcase
            end
            riscv_pkg::OPC_OP_IMM, riscv_pkg::OPC_OP: begin
                ok = !reg_op || f7 == riscv_pkg::F7_BASE;
                r.alusel = riscv_pkg::RES_LOGIC;
                case (inst[14:12])
                    riscv_pkg::F3_ADD: begin
                        r.aluop = (reg_op && f7 == riscv_pkg::F7_ALT) ? riscv_pkg::ALU_SUB
                                                                       : riscv_pkg::ALU_ADD;
                        r.alusel = riscv_pkg::RES_ARITH;
                        ok = !reg_op || f7 == riscv_pkg::F7_BASE || f7 == riscv_pkg::F7_ALT;
                    end
                    riscv_pkg::F3_SLL: begin
                        r.aluop = riscv_pkg::ALU_SLL;
                        r.alusel = riscv_pkg::RES_SHIFT;
                        ok = (f7 == riscv_pkg::F7_BASE);
                        imm2 = {27'b0, inst[24:20]};
                    end
                    riscv_pkg::F3_SR: begin
                        r.aluop = (f7 == riscv_pkg::F7_ALT) ? riscv_pkg::ALU_SRA
                                                            : riscv_pkg::ALU_SRL;
                        r.alusel = riscv_pkg::RES_SHIFT;
                        ok = (f7 == riscv_pkg::F7_BASE || f7 == riscv_pkg::F7_ALT);
                        imm2 = {27'b0, inst[24:20]};
                    end
                    riscv_pkg::F3_SLT: begin
                        r.aluop = riscv_pkg::ALU_SLT;
                        r.alusel = riscv_pkg::RES_COMPARE;
                    end
                    riscv_pkg::F3_SLTU: begin
                        r.aluop = riscv_pkg::ALU_SLTU;
                        r.alusel = riscv_pkg::RES_COMPARE;
                    end
                    riscv_pkg::F3_XOR: r.aluop = riscv_pkg::ALU_XOR;
                    riscv_pkg::F3_OR:  r.aluop = riscv_pkg::ALU_OR;
                    default:           r.aluop = riscv_pkg::ALU_AND;
                endcase
            end
            default: ok = 1'b0;
        endcase
        if (!ok) begin
            r.aluop = riscv_pkg::ALU_NONE;
            r.alusel = riscv_pkg::RES_NONE;
            r.illegal = 1'b1;
            return r;
        end
        r.wreg = 1'b1;
        r.op1 = expected_operand(use1, inst[19:15], r.op1, s1);
        r.op2 = expected_operand(reg_op, inst[24:20], imm2, s2);
        stall = s1 | s2;
        return r;
    endfunction

    task automatic mismatch(
        input string                               what,
        input logic [$bits(pipe_pkg::issue_t)-1:0] e,
        input logic [$bits(pipe_pkg::issue_t)-1:0] a
    );
        errors++;
        test_errors++;
        $display("[FAIL] %s %s expected %h actual %h", test_name, what, e, a);
    endtask

    task automatic compare_issue(input pipe_pkg::issue_t e);
        logic bad;
        checks++;
        if (!e.valid || e.illegal)   // payload is don't care for a bubble or an illegal issue
            bad = issue_i.valid !== e.valid || issue_i.illegal !== e.illegal
                  || issue_i.wreg !== 1'b0 || issue_i.aluop !== riscv_pkg::ALU_NONE;
        else
            bad = (issue_i !== e);
        if (bad) mismatch("issue_o", e, issue_i);
    endtask

    task automatic start_test(input string name);
        test_name = name;
        test_errors = 0;
        tests++;
    endtask

    task automatic end_test();
        $display("test %-12s %s, %0d errors", test_name,
                 test_errors == 0 ? "passed" : "failed", test_errors);
    endtask

    always @(posedge clk) begin
        if (!rst_n_i) begin
            foreach (shadow[i]) shadow[i] = '0;
            exp_valid = 1'b0;
        end else begin
            if (exp_valid) compare_issue(exp_q);
            exp_q = '0;
            if (inst_valid_i) begin
                exp_q = ref_issue(inst_i, pc_i, exp_stall);
                checks++;
                if (ready_i !== !exp_stall) mismatch("ready_o", !exp_stall, ready_i);
                if (exp_stall) exp_q = '0;
            end
            exp_valid = 1'b1;
            // write lands after the read so the same cycle sees the old value
            if (wb_i.we && wb_i.addr != '0) shadow[wb_i.addr] = wb_i.data;
        end
    end

endmodule

// ==== dv/tb_decode_stage.sv ====
`timescale 1ns/1ps

module tb_decode_stage;

    logic             clk;
    logic             rst_n_i;
    logic             inst_valid_i;
    riscv_pkg::word_t pc_i;
    riscv_pkg::inst_t inst_i;
    logic             ready_o;
    pipe_pkg::fwd_t   ex_fwd_i;
    pipe_pkg::fwd_t   mem_fwd_i;
    pipe_pkg::wb_t    wb_i;
    pipe_pkg::issue_t issue_o;
    integer           seed = 32'hf331;

    decode_stage DUT (.*);

    decode_checker u_chk (
        .ready_i (ready_o),
        .issue_i (issue_o),
        .*
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // hi is {funct7, rs2} for R format or imm[11:0] for I format
    function automatic riscv_pkg::inst_t encode(
        input logic [11:0]          hi,
        input riscv_pkg::reg_addr_t rs1,
        input riscv_pkg::funct3_t   f3,
        input riscv_pkg::reg_addr_t rd,
        input riscv_pkg::opcode_t   opc
    );
        return {hi, rs1, f3, rd, opc};
    endfunction

    // legal OP or OP-IMM with register fields limited by reg_mask
    function automatic riscv_pkg::inst_t rand_alu_inst(input logic [4:0] reg_mask);
        riscv_pkg::word_t   r;
        riscv_pkg::funct3_t f3;
        logic [11:0]        hi;
        logic               reg_op;
        r = $random(seed);
        f3 = r[14:12];
        hi = r[31:20];
        reg_op = r[5];
        hi[4:0] = hi[4:0] & reg_mask;
        if (reg_op || f3 == riscv_pkg::F3_SLL)
            hi[11:5] = riscv_pkg::F7_BASE;
        if (f3 == riscv_pkg::F3_SR || (reg_op && f3 == riscv_pkg::F3_ADD))
            hi[11:5] = r[30] ? riscv_pkg::F7_ALT : riscv_pkg::F7_BASE;
        return encode(hi, r[19:15] & reg_mask, f3, r[11:7],
                      reg_op ? riscv_pkg::OPC_OP : riscv_pkg::OPC_OP_IMM);
    endfunction

    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic abort_run(input string why);
        $display("error: %s", why);
        $display("Test FAILED");
        $finish;
    endtask

    task automatic wait_ready();
        int n;
        n = 0;
        #1;   // decode logic settles before ready_o is sampled
        while (!ready_o) begin
            if (n == 16) abort_run("ready_o stayed low, the instruction was never taken");
            step();
            n++;
        end
    endtask

    task automatic issue_inst(input riscv_pkg::inst_t inst, input riscv_pkg::word_t pc);
        inst_valid_i = 1'b1;
        inst_i = inst;
        pc_i = pc;
        wait_ready();
        step();
        inst_valid_i = 1'b0;
    endtask

    task automatic write_reg(input riscv_pkg::reg_addr_t addr, input riscv_pkg::word_t data);
        wb_i = '{we: 1'b1, addr: addr, data: data};
        step();
        wb_i = '0;
    endtask

    task automatic close_test();
        step();
        step();   // last record compared
        u_chk.end_test();
    endtask

    initial begin
        riscv_pkg::inst_t inst;
        riscv_pkg::word_t r;
        rst_n_i = 1'b1;   // clean falling edge for the async reset
        inst_valid_i = 1'b0;
        pc_i = '0;
        inst_i = '0;
        ex_fwd_i = '0;
        mem_fwd_i = '0;
        wb_i = '0;
        #1 rst_n_i = 1'b0;
        repeat (5) @(posedge clk);
        #1 rst_n_i = 1'b1;

        u_chk.start_test("alu_random");
        for (int i = 1; i < riscv_pkg::NUM_REGS; i++)
            write_reg(riscv_pkg::reg_addr_t'(i), $random(seed));
        for (int i = 0; i < 40; i++)
            issue_inst(rand_alu_inst(5'h1f), $random(seed));
        close_test();

        u_chk.start_test("upper_imm");
        for (int i = 0; i < 12; i++) begin
            inst = $random(seed);
            inst[6:0] = inst[31] ? riscv_pkg::OPC_LUI : riscv_pkg::OPC_AUIPC;
            issue_inst(inst, $random(seed));
        end
        close_test();

        u_chk.start_test("forwarding");
        for (int i = 0; i < 40; i++) begin
            r = $random(seed);   // x0..x3 only so hits are frequent
            ex_fwd_i = '{wreg: r[0], rd: {3'b0, r[2:1]}, wdata: $random(seed), is_load: 1'b0};
            mem_fwd_i = '{wreg: r[3], rd: {3'b0, r[5:4]}, wdata: $random(seed), is_load: 1'b0};
            issue_inst(rand_alu_inst(5'h03), r);
        end
        ex_fwd_i = '{wreg: 1'b1, rd: 5'd2, wdata: $random(seed), is_load: 1'b0};
        mem_fwd_i = '{wreg: 1'b1, rd: 5'd2, wdata: $random(seed), is_load: 1'b0};
        issue_inst(encode({7'b0, 5'd2}, 5'd2, riscv_pkg::F3_ADD, 5'd1, riscv_pkg::OPC_OP), '0);
        ex_fwd_i = '0;
        mem_fwd_i = '0;
        close_test();

        u_chk.start_test("load_use");
        for (int k = 0; k < 2; k++) begin
            ex_fwd_i = '{wreg: 1'b1, rd: 5'd7, wdata: $random(seed), is_load: 1'b1};
            inst_valid_i = 1'b1;
            pc_i = $random(seed);
            inst_i = (k == 0)
                ? encode({7'b0, 5'd3}, 5'd7, riscv_pkg::F3_ADD, 5'd1, riscv_pkg::OPC_OP)
                : encode({7'b0, 5'd7}, 5'd3, riscv_pkg::F3_XOR, 5'd1, riscv_pkg::OPC_OP);
            step();
            step();
            ex_fwd_i = '0;   // load has moved on to memory
            wait_ready();
            step();
            inst_valid_i = 1'b0;
        end
        close_test();

        u_chk.start_test("illegal");
        for (int i = 0; i < 30; i++) begin
            inst = $random(seed);
            if (inst[6:0] inside {riscv_pkg::OPC_LUI, riscv_pkg::OPC_AUIPC, riscv_pkg::OPC_OP_IMM,
                                  riscv_pkg::OPC_OP, riscv_pkg::OPC_LOAD})
                inst[6:0] = 7'b1100011;   // branch
            issue_inst(inst, $random(seed));
        end
        issue_inst(encode({7'b0000001, 5'd2}, 5'd1, 3'b000, 5'd3, riscv_pkg::OPC_OP), '0);
        issue_inst(encode(12'h123, 5'd1, 3'b111, 5'd3, riscv_pkg::OPC_LOAD), '0);
        close_test();

        u_chk.start_test("rf_bypass");
        inst = encode(12'h000, 5'd9, riscv_pkg::F3_ADD, 5'd1, riscv_pkg::OPC_OP_IMM);
        wb_i = '{we: 1'b1, addr: 5'd9, data: $random(seed)};
        issue_inst(inst, 32'h100);
        wb_i = '0;
        issue_inst(inst, 32'h104);
        close_test();

        $display("%0d tests, %0d checks, %0d errors, %0d assertion failures",
                 u_chk.tests, u_chk.checks, u_chk.errors, DUT.u_assert.fails);
        if (u_chk.errors == 0 && DUT.u_assert.fails == 0)
            $display("Test OK");
        else
            $display("Test FAILED");
        $finish;
    end

endmodule

// ==== sources.f ====
design/riscv_pkg.sv
design/pipe_pkg.sv
design/inst_decoder.sv
design/regfile.sv
design/operand_select.sv
design/id_ex_reg.sv
design/decode_stage.sv
dv/decode_stage_assert.sv
dv/decode_checker.sv
dv/tb_decode_stage.sv

// ==== Bender.yml ====
package:
  name: decode_stage

sources:
  - design/riscv_pkg.sv
  - design/pipe_pkg.sv
  - design/inst_decoder.sv
  - design/regfile.sv
  - design/operand_select.sv
  - design/id_ex_reg.sv
  - design/decode_stage.sv
  - target: simulation
    files:
      - dv/decode_stage_assert.sv
      - dv/decode_checker.sv
      - dv/tb_decode_stage.sv
